// File: cmo_cfg_pkg.sv
// Cache geometry, flush queue sizing and address, set, tag, line and way types
package cmo_cfg_pkg;

    // Request address and line layout
    localparam int ADDR_W      = 16;
    localparam int CL_OFFSET_W = 4;

    // Directory geometry
    localparam int SETS    = 8;
    localparam int SET_W   = 3;
    localparam int WAYS    = 4;
    localparam int TAG_W   = 9;
    localparam int NLINE_W = SET_W + TAG_W;

    // Flush allocation queue
    localparam int FLUSH_FIFO_DEPTH = 3;
    localparam int FLUSH_PTR_W      = 2;
    // Count must reach the full depth
    localparam int FLUSH_CNT_W      = 2;

    typedef logic [ADDR_W-1:0]  cmo_addr_t;
    typedef logic [SET_W-1:0]   cmo_set_t;
    typedef logic [TAG_W-1:0]   cmo_tag_t;

    // Tag in the upper bits, set in the lower bits
    typedef logic [NLINE_W-1:0] cmo_nline_t;

    // One-hot way select or way mask
    typedef logic [WAYS-1:0]    cmo_way_vec_t;

endpackage

// File: cmo_op_pkg.sv
// Opcode enum, request and status structs, directory and flush allocation structs
package cmo_op_pkg;

    import cmo_cfg_pkg::*;

    typedef enum logic [2:0] {
        CMO_FENCE       = 3'd0,
        CMO_INVAL_NLINE = 3'd1,
        CMO_INVAL_ALL   = 3'd2,
        CMO_FLUSH_NLINE = 3'd3,
        CMO_FLUSH_ALL   = 3'd4
    } cmo_op_e;

    typedef struct packed {
        cmo_op_e   op;
        cmo_addr_t addr;
    } cmo_req_t;

    // Levels driven by the rest of the cache
    typedef struct packed {
        logic wbuf_empty;
        logic mshr_empty;
        logic rtab_empty;
        logic ctrl_empty;
    } cmo_status_t;

    typedef struct packed {
        cmo_tag_t tag;
        cmo_set_t set;
    } dir_nline_chk_t;

    typedef struct packed {
        cmo_set_t     set;
        cmo_way_vec_t way;
    } dir_entry_chk_t;

    typedef struct packed {
        logic     valid;
        logic     dirty;
        cmo_tag_t tag;
    } dir_entry_rsp_t;

    // Hit way is all zeros on a miss
    typedef struct packed {
        cmo_way_vec_t hit_way;
        logic         dirty;
    } dir_nline_rsp_t;

    typedef struct packed {
        cmo_set_t     set;
        cmo_way_vec_t way;
    } dir_inval_t;

    typedef struct packed {
        cmo_nline_t   nline;
        cmo_way_vec_t way;
    } flush_alloc_t;

endpackage

// File: cmo_set_way_walker.sv
// Set and one-hot way counters for whole-cache walks, with last-set and last-way flags
`timescale 1ns/10ps

module cmo_set_way_walker
    import cmo_cfg_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         step_i,
    input  logic         restart_i,

    output cmo_set_t     set_o,
    output cmo_way_vec_t way_o,
    output logic         set_last_o,
    output logic         way_last_o
);

    cmo_set_t     set_q, set_d;
    cmo_way_vec_t way_q, way_d;

    assign set_o      = set_q;
    assign way_o      = way_q;
    assign set_last_o = (set_q == cmo_set_t'(SETS - 1));
    assign way_last_o = way_q[WAYS-1];

    always_comb begin
        set_d = set_q;
        way_d = way_q;
        if (restart_i) begin
            set_d = '0;
            way_d = cmo_way_vec_t'(1);
        end else if (step_i) begin
            // Ways innermost, set moves on after the last way
            way_d = {way_q[WAYS-2:0], way_q[WAYS-1]};
            if (way_last_o) begin
                set_d = set_last_o ? '0 : set_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            set_q <= '0;
            way_q <= cmo_way_vec_t'(1);
        end else begin
            set_q <= set_d;
            way_q <= way_d;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot(way_o))
        else $error("cmo_set_way_walker: way select not one-hot");

endmodule

// File: cmo_flush_fifo.sv
// Three-entry feedthrough register queue for flush allocations
`timescale 1ns/10ps

module cmo_flush_fifo
    import cmo_cfg_pkg::*;
    import cmo_op_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         push_i,
    input  flush_alloc_t push_data_i,
    output logic         has_room_o,

    output logic         valid_o,
    output flush_alloc_t data_o,
    input  logic         ready_i
);

    flush_alloc_t           mem_q [FLUSH_FIFO_DEPTH];
    logic [FLUSH_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [FLUSH_CNT_W-1:0] count_q;
    logic                   empty;
    logic                   bypass;
    logic                   wr_en;
    logic                   rd_en;

    function automatic logic [FLUSH_PTR_W-1:0] next_ptr(logic [FLUSH_PTR_W-1:0] ptr);
        return (ptr == FLUSH_PTR_W'(FLUSH_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count_q == '0);

    // Empty queue passes the pushed entry straight to the head
    assign valid_o = !empty || push_i;
    assign data_o  = empty ? push_data_i : mem_q[rd_ptr_q];

    assign bypass = empty && push_i && ready_i;
    assign wr_en  = push_i && !bypass;
    assign rd_en  = !empty && ready_i;

    // Room left after a push in this same cycle, pops not counted
    assign has_room_o = count_q < (push_i ? FLUSH_CNT_W'(FLUSH_FIFO_DEPTH - 1)
                                          : FLUSH_CNT_W'(FLUSH_FIFO_DEPTH));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (rd_en) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_q + FLUSH_CNT_W'(wr_en) - FLUSH_CNT_W'(rd_en);
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> (count_q != FLUSH_CNT_W'(FLUSH_FIFO_DEPTH)))
        else $error("cmo_flush_fifo: push into full queue");

    // Back-pressure keeps the head in place
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
        else $error("cmo_flush_fifo: head changed under back-pressure");

endmodule

// File: cmo_ctrl_fsm.sv
// CMO controller FSM: request intake, quiescence wait, directory checks, invalidations, flushes
`timescale 1ns/10ps

module cmo_ctrl_fsm
    import cmo_cfg_pkg::*;
    import cmo_op_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    input  logic           req_valid_i,
    input  cmo_req_t       req_i,
    output logic           req_ready_o,
    output logic           req_wait_o,

    input  cmo_status_t    status_i,
    output logic           wbuf_flush_all_o,

    output logic           dir_nline_chk_o,
    output dir_nline_chk_t dir_nline_chk_data_o,
    input  dir_nline_rsp_t dir_nline_rsp_i,

    output logic           dir_entry_chk_o,
    output dir_entry_chk_t dir_entry_chk_data_o,
    input  dir_entry_rsp_t dir_entry_rsp_i,

    output logic           dir_inval_o,
    output dir_inval_t     dir_inval_data_o,

    output logic           walk_step_o,
    output logic           walk_restart_o,
    input  cmo_set_t       walk_set_i,
    input  cmo_way_vec_t   walk_way_i,
    input  logic           walk_set_last_i,
    input  logic           walk_way_last_i,

    output logic           push_o,
    output flush_alloc_t   push_data_o,
    input  logic           has_room_i
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_FENCE_WAIT,
        ST_WAIT_QUIET,
        ST_INVAL_NLINE_CHK,
        ST_INVAL_NLINE_SET,
        ST_INVAL_ALL,
        ST_FLUSH_NLINE_CHK,
        ST_FLUSH_NLINE_PUSH,
        ST_FLUSH_ALL_WALK,
        ST_FLUSH_ALL_DRAIN
    } cmo_state_e;

    cmo_state_e     state_q, state_d;
    cmo_op_e        op_q, op_d;
    cmo_addr_t      addr_q, addr_d;
    cmo_set_t       inval_set_q, inval_set_d;

    // Entry check issued last cycle, paired with this cycle's answer
    logic           pend_valid_q, pend_valid_d;
    dir_entry_chk_t pend_q, pend_d;

    cmo_nline_t     addr_nline;
    cmo_set_t       addr_set;
    cmo_tag_t       addr_tag;
    logic           quiet;
    logic           nline_hit;
    logic           entry_push;

    function automatic cmo_state_e first_state(cmo_op_e op);
        cmo_state_e st;
        case (op)
            CMO_INVAL_NLINE: st = ST_INVAL_NLINE_CHK;
            CMO_INVAL_ALL:   st = ST_INVAL_ALL;
            CMO_FLUSH_NLINE: st = ST_FLUSH_NLINE_CHK;
            CMO_FLUSH_ALL:   st = ST_FLUSH_ALL_WALK;
            default:         st = ST_IDLE;
        endcase
        return st;
    endfunction

    assign addr_nline = addr_q[CL_OFFSET_W +: NLINE_W];
    assign addr_set   = addr_nline[SET_W-1:0];
    assign addr_tag   = addr_nline[NLINE_W-1 -: TAG_W];

    assign quiet     = status_i.mshr_empty & status_i.rtab_empty & status_i.ctrl_empty;
    assign nline_hit = |dir_nline_rsp_i.hit_way;

    // Only high in the cycle after an entry check of the flush-all walk
    assign entry_push = pend_valid_q & dir_entry_rsp_i.valid & dir_entry_rsp_i.dirty;

    assign req_ready_o = (state_q == ST_IDLE);
    assign req_wait_o  = (state_q == ST_FENCE_WAIT) || (state_q == ST_WAIT_QUIET);

    assign dir_nline_chk_data_o = '{tag: addr_tag, set: addr_set};
    assign dir_entry_chk_data_o = '{set: walk_set_i, way: walk_way_i};

    always_comb begin
        state_d      = state_q;
        op_d         = op_q;
        addr_d       = addr_q;
        inval_set_d  = inval_set_q;
        pend_valid_d = 1'b0;
        pend_d       = pend_q;

        walk_step_o      = 1'b0;
        walk_restart_o   = 1'b0;
        wbuf_flush_all_o = 1'b0;
        dir_nline_chk_o  = 1'b0;
        dir_entry_chk_o  = 1'b0;
        dir_inval_o      = 1'b0;
        dir_inval_data_o = '{set: addr_set, way: '0};

        push_o      = entry_push;
        push_data_o = '{nline: {dir_entry_rsp_i.tag, pend_q.set}, way: pend_q.way};

        unique case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    op_d           = req_i.op;
                    addr_d         = req_i.addr;
                    inval_set_d    = '0;
                    walk_restart_o = 1'b1;
                    if (req_i.op == CMO_FENCE) begin
                        // Drain the write buffer once the replay table is empty
                        wbuf_flush_all_o = status_i.rtab_empty;
                        if (!(status_i.wbuf_empty && status_i.rtab_empty)) begin
                            state_d = ST_FENCE_WAIT;
                        end
                    end else if (quiet) begin
                        state_d = first_state(req_i.op);
                    end else begin
                        state_d = ST_WAIT_QUIET;
                    end
                end
            end
            ST_FENCE_WAIT: begin
                wbuf_flush_all_o = status_i.rtab_empty;
                if (status_i.wbuf_empty && status_i.rtab_empty) begin
                    state_d = ST_IDLE;
                end
            end
            ST_WAIT_QUIET: begin
                if (quiet) begin
                    state_d = first_state(op_q);
                end
            end
            ST_INVAL_NLINE_CHK: begin
                dir_nline_chk_o = 1'b1;
                state_d         = ST_INVAL_NLINE_SET;
            end
            ST_INVAL_NLINE_SET: begin
                dir_inval_o      = nline_hit;
                dir_inval_data_o = '{set: addr_set, way: dir_nline_rsp_i.hit_way};
                state_d          = ST_IDLE;
            end
            ST_INVAL_ALL: begin
                // One set per cycle, all ways at once
                dir_inval_o      = 1'b1;
                dir_inval_data_o = '{set: inval_set_q, way: '1};
                inval_set_d      = inval_set_q + 1'b1;
                if (inval_set_q == cmo_set_t'(SETS - 1)) begin
                    state_d = ST_IDLE;
                end
            end
            ST_FLUSH_NLINE_CHK: begin
                // Hold the check until a slot is free for the push
                if (has_room_i) begin
                    dir_nline_chk_o = 1'b1;
                    state_d         = ST_FLUSH_NLINE_PUSH;
                end
            end
            ST_FLUSH_NLINE_PUSH: begin
                push_o      = nline_hit & dir_nline_rsp_i.dirty;
                push_data_o = '{nline: addr_nline, way: dir_nline_rsp_i.hit_way};
                state_d     = ST_IDLE;
            end
            ST_FLUSH_ALL_WALK: begin
                if (has_room_i) begin
                    dir_entry_chk_o = 1'b1;
                    walk_step_o     = 1'b1;
                    pend_valid_d    = 1'b1;
                    pend_d          = '{set: walk_set_i, way: walk_way_i};
                    if (walk_set_last_i && walk_way_last_i) begin
                        state_d = ST_FLUSH_ALL_DRAIN;
                    end
                end
            end
            ST_FLUSH_ALL_DRAIN: begin
                // Answer to the last entry check is pushed by the default above
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= ST_IDLE;
            inval_set_q  <= '0;
            pend_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            inval_set_q  <= inval_set_d;
            pend_valid_q <= pend_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        op_q   <= op_d;
        addr_q <= addr_d;
        pend_q <= pend_d;
    end

    // Requester must wait for ready
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> req_ready_o)
        else $error("cmo_ctrl_fsm: request while busy");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (req_valid_i && req_ready_o) |-> (req_i.op inside {CMO_FENCE, CMO_INVAL_NLINE,
                                          CMO_INVAL_ALL, CMO_FLUSH_NLINE, CMO_FLUSH_ALL}))
        else $error("cmo_ctrl_fsm: illegal opcode %0d", req_i.op);

endmodule

// File: cmo_handler.sv
// CMO handler top level connecting the controller, set/way walker and flush queue
`timescale 1ns/10ps

module cmo_handler
    import cmo_cfg_pkg::*;
    import cmo_op_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    input  logic           req_valid_i,
    input  cmo_req_t       req_i,
    output logic           req_ready_o,
    output logic           req_wait_o,

    input  cmo_status_t    status_i,
    output logic           wbuf_flush_all_o,

    output logic           dir_nline_chk_o,
    output dir_nline_chk_t dir_nline_chk_data_o,
    input  dir_nline_rsp_t dir_nline_rsp_i,

    output logic           dir_entry_chk_o,
    output dir_entry_chk_t dir_entry_chk_data_o,
    input  dir_entry_rsp_t dir_entry_rsp_i,

    output logic           dir_inval_o,
    output dir_inval_t     dir_inval_data_o,

    output logic           flush_alloc_valid_o,
    output flush_alloc_t   flush_alloc_o,
    input  logic           flush_alloc_ready_i
);

    // Walker handshake
    logic         walk_step;
    logic         walk_restart;
    cmo_set_t     walk_set;
    cmo_way_vec_t walk_way;
    logic         walk_set_last;
    logic         walk_way_last;

    // Flush queue write side
    logic         push;
    flush_alloc_t push_data;
    logic         has_room;

    cmo_ctrl_fsm u_ctrl (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .req_valid_i          (req_valid_i),
        .req_i                (req_i),
        .req_ready_o          (req_ready_o),
        .req_wait_o           (req_wait_o),
        .status_i             (status_i),
        .wbuf_flush_all_o     (wbuf_flush_all_o),
        .dir_nline_chk_o      (dir_nline_chk_o),
        .dir_nline_chk_data_o (dir_nline_chk_data_o),
        .dir_nline_rsp_i      (dir_nline_rsp_i),
        .dir_entry_chk_o      (dir_entry_chk_o),
        .dir_entry_chk_data_o (dir_entry_chk_data_o),
        .dir_entry_rsp_i      (dir_entry_rsp_i),
        .dir_inval_o          (dir_inval_o),
        .dir_inval_data_o     (dir_inval_data_o),
        .walk_step_o          (walk_step),
        .walk_restart_o       (walk_restart),
        .walk_set_i           (walk_set),
        .walk_way_i           (walk_way),
        .walk_set_last_i      (walk_set_last),
        .walk_way_last_i      (walk_way_last),
        .push_o               (push),
        .push_data_o          (push_data),
        .has_room_i           (has_room)
    );

    cmo_set_way_walker u_walker (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .step_i     (walk_step),
        .restart_i  (walk_restart),
        .set_o      (walk_set),
        .way_o      (walk_way),
        .set_last_o (walk_set_last),
        .way_last_o (walk_way_last)
    );

    cmo_flush_fifo u_flush_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_data_i (push_data),
        .has_room_o  (has_room),
        .valid_o     (flush_alloc_valid_o),
        .data_o      (flush_alloc_o),
        .ready_i     (flush_alloc_ready_i)
    );

endmodule

// File: tb_cmo_dir_model.sv
// Behavioral cache directory with registered check answers, invalidation and load port
`timescale 1ns/10ps

module tb_cmo_dir_model
    import cmo_cfg_pkg::*;
    import cmo_op_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    input  logic           nline_chk_i,
    input  dir_nline_chk_t nline_chk_data_i,
    output dir_nline_rsp_t nline_rsp_o,

    input  logic           entry_chk_i,
    input  dir_entry_chk_t entry_chk_data_i,
    output dir_entry_rsp_t entry_rsp_o,

    input  logic           inval_i,
    input  dir_inval_t     inval_data_i,

    // Writes one entry per way selected in the mask
    input  logic           load_i,
    input  cmo_set_t       load_set_i,
    input  cmo_way_vec_t   load_way_i,
    input  dir_entry_rsp_t load_entry_i
);

    logic     valid_q [SETS][WAYS];
    logic     dirty_q [SETS][WAYS];
    cmo_tag_t tag_q   [SETS][WAYS];

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nline_rsp_o <= '0;
            entry_rsp_o <= '0;
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                    tag_q[s][w]   <= '0;
                end
            end
        end else begin
            // Answers last one cycle only
            nline_rsp_o <= '0;
            entry_rsp_o <= '0;
            for (int w = 0; w < WAYS; w++) begin
                if (nline_chk_i && valid_q[nline_chk_data_i.set][w]
                        && (tag_q[nline_chk_data_i.set][w] == nline_chk_data_i.tag)) begin
                    nline_rsp_o.hit_way[w] <= 1'b1;
                    nline_rsp_o.dirty      <= dirty_q[nline_chk_data_i.set][w];
                end
                if (entry_chk_i && entry_chk_data_i.way[w]) begin
                    entry_rsp_o.valid <= valid_q[entry_chk_data_i.set][w];
                    entry_rsp_o.dirty <= dirty_q[entry_chk_data_i.set][w];
                    entry_rsp_o.tag   <= tag_q[entry_chk_data_i.set][w];
                end
                if (inval_i && inval_data_i.way[w]) begin
                    valid_q[inval_data_i.set][w] <= 1'b0;
                end
                if (load_i && load_way_i[w]) begin
                    valid_q[load_set_i][w] <= load_entry_i.valid;
                    dirty_q[load_set_i][w] <= load_entry_i.dirty;
                    tag_q[load_set_i][w]   <= load_entry_i.tag;
                end
            end
        end
    end

endmodule

// File: tb_cmo_handler.sv
// Testbench for the CMO handler with flush reference list and allocation checker
`timescale 1ns/10ps

module tb_cmo_handler
    import cmo_cfg_pkg::*;
    import cmo_op_pkg::*;
();

    localparam int CLK_HALF   = 10;
    localparam int RST_CYCLES = 16;
    // Three times the worst case of 32 walk steps under random stall plus the other tests
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        cmo_set_t     set;
        cmo_way_vec_t way;
        int           cycle;
    } inval_rec_t;

    logic           clk;
    logic           rst_n;
    logic           req_valid;
    cmo_req_t       req;
    logic           req_ready;
    logic           req_wait;
    cmo_status_t    status;
    logic           wbuf_flush_all;
    logic           nline_chk;
    dir_nline_chk_t nline_chk_data;
    dir_nline_rsp_t nline_rsp;
    logic           entry_chk;
    dir_entry_chk_t entry_chk_data;
    dir_entry_rsp_t entry_rsp;
    logic           dir_inval;
    dir_inval_t     dir_inval_data;
    logic           flush_valid;
    flush_alloc_t   flush_alloc;
    logic           flush_ready;

    logic           load;
    cmo_set_t       load_set;
    cmo_way_vec_t   load_way;
    dir_entry_rsp_t load_entry;

    integer         seed;
    logic           bp_en;
    int             cycle_cnt;
    int             mismatch_cnt;
    int             other_cnt;
    int             access_cnt;
    flush_alloc_t   exp_q [$];
    inval_rec_t     inval_log [$];

    cmo_handler DUT (
        .clk_i                (clk),
        .rst_ni               (rst_n),
        .req_valid_i          (req_valid),
        .req_i                (req),
        .req_ready_o          (req_ready),
        .req_wait_o           (req_wait),
        .status_i             (status),
        .wbuf_flush_all_o     (wbuf_flush_all),
        .dir_nline_chk_o      (nline_chk),
        .dir_nline_chk_data_o (nline_chk_data),
        .dir_nline_rsp_i      (nline_rsp),
        .dir_entry_chk_o      (entry_chk),
        .dir_entry_chk_data_o (entry_chk_data),
        .dir_entry_rsp_i      (entry_rsp),
        .dir_inval_o          (dir_inval),
        .dir_inval_data_o     (dir_inval_data),
        .flush_alloc_valid_o  (flush_valid),
        .flush_alloc_o        (flush_alloc),
        .flush_alloc_ready_i  (flush_ready)
    );

    tb_cmo_dir_model dir_model (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .nline_chk_i      (nline_chk),
        .nline_chk_data_i (nline_chk_data),
        .nline_rsp_o      (nline_rsp),
        .entry_chk_i      (entry_chk),
        .entry_chk_data_i (entry_chk_data),
        .entry_rsp_o      (entry_rsp),
        .inval_i          (dir_inval),
        .inval_data_i     (dir_inval_data),
        .load_i           (load),
        .load_set_i       (load_set),
        .load_way_i       (load_way),
        .load_entry_i     (load_entry)
    );

    always #(CLK_HALF) clk = ~clk;

    // Inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic report_failure(input string msg);
        other_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic cmo_addr_t line_addr(input cmo_set_t set, input cmo_tag_t tag);
        return {tag, set, {CL_OFFSET_W{1'b0}}};
    endfunction

    // Valid dirty entries in walk order or the one entry of a single line
    function automatic void expected_flush_list(input logic whole_cache, input cmo_addr_t addr);
        cmo_nline_t nline;
        cmo_set_t   line_set;
        cmo_tag_t   line_tag;
        nline    = addr[CL_OFFSET_W +: NLINE_W];
        line_set = nline[SET_W-1:0];
        line_tag = nline[NLINE_W-1 -: TAG_W];
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                if (dir_model.valid_q[s][w] && dir_model.dirty_q[s][w]
                        && (whole_cache || ((s == int'(line_set))
                                            && (dir_model.tag_q[s][w] == line_tag)))) begin
                    exp_q.push_back('{nline: {dir_model.tag_q[s][w], cmo_set_t'(s)},
                                      way: cmo_way_vec_t'(1) << w});
                end
            end
        end
    endfunction

    task automatic load_one(input int s, input int w, input logic v, input logic d,
                            input cmo_tag_t tag);
        load       = 1'b1;
        load_set   = cmo_set_t'(s);
        load_way   = cmo_way_vec_t'(1) << w;
        load_entry = '{valid: v, dirty: d, tag: tag};
        tick();
        load = 1'b0;
    endtask

    task automatic load_directory();
        logic [31:0] rnd;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                rnd = $random(seed);
                // Low tag bits carry the way so tags never repeat within a set
                load_one(s, w, rnd[0] | rnd[1], rnd[2], {rnd[10:4], 2'(w)});
            end
        end
        // Known entries for the by-line tests
        load_one(1, 0, 1'b1, 1'b1, {7'h2a, 2'd0});
        load_one(1, 1, 1'b1, 1'b0, {7'h13, 2'd1});
        load_one(2, 3, 1'b1, 1'b1, {7'h55, 2'd3});
    endtask

    task automatic send_req(input cmo_op_e op, input cmo_addr_t addr);
        while (!req_ready) begin
            tick();
        end
        req_valid = 1'b1;
        req       = '{op: op, addr: addr};
        tick();
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (!req_ready) begin
            tick();
        end
    endtask

    task automatic wait_drain();
        while (flush_valid) begin
            tick();
        end
    endtask

    task automatic check_flush_done();
        assert (exp_q.size() == 0) else begin
            report_failure($sformatf("%0d expected flush allocations never appeared",
                                     exp_q.size()));
        end
        exp_q.delete();
    endtask

    task automatic flush_line(input cmo_addr_t addr);
        expected_flush_list(1'b0, addr);
        send_req(CMO_FLUSH_NLINE, addr);
        wait_idle();
        wait_drain();
        check_flush_done();
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
            $display("test failed");
            $finish;
        end
    end

    // Random back-pressure with ready high about one cycle in four
    always @(posedge clk) begin : drive_ready
        logic [31:0] rnd;
        logic        bp_now;
        bp_now = bp_en;
        #2;
        if (bp_now) begin
            rnd         = $random(seed);
            flush_ready = (rnd[1:0] == 2'b00);
        end else begin
            flush_ready = 1'b1;
        end
    end

    // Directory traffic log
    always @(negedge clk) begin
        if (rst_n) begin
            if (nline_chk || entry_chk || dir_inval) begin
                access_cnt++;
            end
            if (dir_inval) begin
                inval_log.push_back('{set: dir_inval_data.set, way: dir_inval_data.way,
                                      cycle: cycle_cnt});
            end
        end
    end

    always @(negedge clk) begin : compare_flush
        flush_alloc_t exp;
        if (rst_n && flush_valid && flush_ready) begin
            assert (exp_q.size() > 0) else begin
                report_failure($sformatf("unexpected flush allocation %0h", flush_alloc));
            end
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                check_value("flush_alloc_o", 32'(flush_alloc), 32'(exp));
            end
        end
    end

    initial begin
        int         base_access;
        cmo_addr_t  hit_addr;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        status       = '1;
        load         = 1'b0;
        load_set     = '0;
        load_way     = '0;
        load_entry   = '0;
        flush_ready  = 1'b1;
        bp_en        = 1'b0;
        seed         = 32'h8628;
        cycle_cnt    = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        access_cnt   = 0;

        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("req_ready_o", req_ready, 1);
        check_value("req_wait_o", req_wait, 0);
        check_value("flush_alloc_valid_o", flush_valid, 0);
        check_value("dir_inval_o", dir_inval, 0);
        check_value("dir_nline_chk_o", nline_chk, 0);
        check_value("dir_entry_chk_o", entry_chk, 0);
        tick();
        load_directory();

        // Fence with the write buffer busy and the replay table toggling
        status.wbuf_empty = 1'b0;
        send_req(CMO_FENCE, '0);
        for (int i = 0; i < 4; i++) begin
            status.rtab_empty = (i != 1) && (i != 2);
            @(negedge clk);
            check_value("req_wait_o", req_wait, 1);
            check_value("req_ready_o", req_ready, 0);
            check_value("wbuf_flush_all_o", wbuf_flush_all, status.rtab_empty);
            tick();
        end
        status.wbuf_empty = 1'b1;
        @(negedge clk);
        check_value("req_ready_o", req_ready, 0);
        tick();
        @(negedge clk);
        check_value("req_ready_o", req_ready, 1);
        check_value("req_wait_o", req_wait, 0);
        tick();
        // Quiet fence completes in its acceptance cycle
        send_req(CMO_FENCE, '0);
        @(negedge clk);
        check_value("req_ready_o", req_ready, 1);
        tick();

        // Invalidate by line with a hit and then a miss on the same line
        hit_addr = line_addr(3'd2, {7'h55, 2'd3});
        inval_log.delete();
        send_req(CMO_INVAL_NLINE, hit_addr);
        wait_idle();
        check_value("dir_inval_o count", inval_log.size(), 1);
        if (inval_log.size() == 1) begin
            check_value("dir_inval_data_o.set", inval_log[0].set, 2);
            check_value("dir_inval_data_o.way", inval_log[0].way, 4'b1000);
        end
        check_value("model valid[2][3]", dir_model.valid_q[2][3], 0);
        inval_log.delete();
        send_req(CMO_INVAL_NLINE, hit_addr);
        wait_idle();
        check_value("dir_inval_o count", inval_log.size(), 0);

        // Flush by line with a dirty hit, a clean hit and a miss
        flush_line(line_addr(3'd1, {7'h2a, 2'd0}));
        flush_line(line_addr(3'd1, {7'h13, 2'd1}));
        flush_line(hit_addr);

        // Flush all under random back-pressure
        bp_en = 1'b1;
        expected_flush_list(1'b1, '0);
        send_req(CMO_FLUSH_ALL, '0);
        wait_idle();
        wait_drain();
        bp_en = 1'b0;
        check_flush_done();

        // Invalidate all behind a busy MSHR
        status.mshr_empty = 1'b0;
        inval_log.delete();
        base_access = access_cnt;
        send_req(CMO_INVAL_ALL, '0);
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_value("req_wait_o", req_wait, 1);
            tick();
        end
        assert (access_cnt == base_access) else begin
            report_failure("directory accessed while waiting for mshr_empty");
        end
        status.mshr_empty = 1'b1;
        wait_idle();
        check_value("dir_inval_o count", inval_log.size(), SETS);
        for (int i = 0; i < inval_log.size(); i++) begin
            check_value("dir_inval_data_o.set", inval_log[i].set, i);
            check_value("dir_inval_data_o.way", inval_log[i].way, 4'b1111);
            check_value("dir_inval_o cycle", inval_log[i].cycle, inval_log[0].cycle + i);
        end
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                check_value($sformatf("model valid[%0d][%0d]", s, w),
                            dir_model.valid_q[s][w], 0);
            end
        end

        tick();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: cmo_handler.f
cmo_cfg_pkg.sv
cmo_op_pkg.sv
cmo_set_way_walker.sv
cmo_flush_fifo.sv
cmo_ctrl_fsm.sv
cmo_handler.sv
tb_cmo_dir_model.sv
tb_cmo_handler.sv

// File: run_sim.sh
#!/bin/sh
# Build the CMO handler testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cmo_handler -f cmo_handler.f -o sim_cmo_handler
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cmo_handler)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
